// File: sim.f
src/if_pkg.sv
src/fetch_beat_if.sv
src/fetch_fsm.sv
src/pc_counter.sv
src/branch_target_unit.sv
src/inst_capture.sv
src/if_stage_top.sv
sim/rd_mem_model.sv
sim/if_stage_chk.sv
sim/tb_if_stage.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_if_stage
FILELIST  = sim.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/if_testdata.hex
// memory image: 32-bit words from 0x8000_0000, eight per line
// step records at @40: exp_pc exp_inst kind a b c, all zero ends the list
// kind 0 none, 1 jal, 2 branch, 3 jalr, 4 panic, 5 stall, 6 jal with jalr
// a is me_pc and mtvec, b is imm, c is alu result and r1
@00
10000013 10000113 10000213 10000313 10000413 10000513 10000613 10000713
10000813 10000913 10000a13 10000b13 10000c13 10000d13 10000e13 10000f13
10001013 10001113 10001213 10001313 10001413 10001513 10001613 10001713
10001813 10001913 10001a13 10001b13 10001c13 10001d13 10001e13 10001f13
@40
80000000 10000013 0 0 0 0
80000004 10000113 0 0 0 0
80000008 10000213 1 80000008 20 0
80000028 10000a13 2 80000028 fffffffffffffff8 0
80000020 10000813 2 80000020 40 1
80000024 10000913 3 0 8 80000041
80000048 10001213 6 80000048 c 80000000
80000054 10001513 4 80000070 0 0
80000070 10001c13 5 0 0 0
80000074 10001d13 0 0 0 0
80000074 10001d13 0 0 0 0
80000078 10001e13 3 0 1 80000200
80000200 da5a585a 0 0 0 0
80000204 da5a585e 1 80000204 fffffffffffffe10 0
80000014 10000513 0 0 0 0
80000018 10000613 5 0 0 0
8000001c 10000713 0 0 0 0
8000001c 10000713 0 0 0 0
80000020 10000813 0 0 0 0
0 0 0 0 0 0

// File: sim/tb_if_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_if_stage;

    localparam int IMAGE_WORDS = 32;
    localparam int STEP_BASE   = 64;
    localparam int STEP_WORDS  = 6;
    localparam int TIMEOUT     = 100;

    // size code of an instruction read on the bus
    localparam if_pkg::rsize_t EXP_SIZE = 8'h0F;

    // step kinds as coded in the data file
    localparam int K_JAL      = 1;
    localparam int K_BRANCH   = 2;
    localparam int K_JALR     = 3;
    localparam int K_PANIC    = 4;
    localparam int K_STALL    = 5;
    localparam int K_JAL_JALR = 6;

    logic           clk;
    logic           rst;
    logic           pc_delay;
    logic           jal;
    logic           jalr;
    logic           branch;
    logic           panic;
    if_pkg::xlen_t  alu_res;
    if_pkg::addr_t  mtvec;
    if_pkg::addr_t  me_pc;
    if_pkg::xlen_t  imm;
    if_pkg::xlen_t  r1_data;
    if_pkg::inst_t  inst_o;
    if_pkg::addr_t  pc_o;
    logic           r_valid;
    logic           r_ready;
    if_pkg::addr_t  r_addr;
    if_pkg::rsize_t r_size;
    logic           data_valid;
    if_pkg::rdata_t data_read;
    logic           data_ready;

    logic [63:0] tdata [0:255];
    int          errors;
    int          timeouts;

    if_stage_top u_dut (
        .clk (clk), .rst_i (rst), .pc_delay_i (pc_delay),
        .jal_i (jal), .jalr_i (jalr), .branch_i (branch), .panic_i (panic),
        .alu_res_i (alu_res), .mtvec_i (mtvec), .me_pc_i (me_pc), .imm_i (imm),
        .r1_data_i (r1_data), .inst_o (inst_o), .pc_o (pc_o),
        .r_valid_o (r_valid), .r_ready_i (r_ready), .r_addr_o (r_addr), .r_size_o (r_size),
        .data_valid_i (data_valid), .data_read_i (data_read), .data_ready_o (data_ready)
    );

    rd_mem_model u_mem (
        .clk (clk), .rst_i (rst), .r_valid_i (r_valid), .r_ready_o (r_ready),
        .r_addr_i (r_addr), .data_ready_i (data_ready), .data_valid_o (data_valid),
        .data_read_o (data_read)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic check_pc(input if_pkg::addr_t got, input if_pkg::addr_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: %s pc is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_inst(input if_pkg::inst_t got, input if_pkg::inst_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: %s instruction is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_size(input if_pkg::rsize_t got, input if_pkg::rsize_t exp,
                              input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0d ns: %s size code is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic clear_redirect();
        {jal, jalr, branch, panic} = 4'b0;
        alu_res = '0;
        mtvec   = '0;
        me_pc   = '0;
        imm     = '0;
        r1_data = '0;
    endtask

    // redirects last one cycle and a stall stays on until the next output
    task automatic apply_step(input int kind, input logic [63:0] a, b, c);
        me_pc   = a;
        mtvec   = a;
        imm     = b;
        alu_res = c;
        r1_data = c;
        jal     = (kind == K_JAL) || (kind == K_JAL_JALR);
        jalr    = (kind == K_JALR) || (kind == K_JAL_JALR);
        branch  = (kind == K_BRANCH);
        panic   = (kind == K_PANIC);
        pc_delay = (kind == K_STALL);
        @(negedge clk);
        clear_redirect();
    endtask

    // reference pc after an output by the redirect rules
    function automatic if_pkg::addr_t next_pc(input int kind, input if_pkg::addr_t pc,
                                              input logic [63:0] a, b, c);
        case (kind)
            K_JAL, K_JAL_JALR: return a + b;
            K_BRANCH: return (c == 64'd0) ? a + b : pc + 64'd4;
            K_JALR: return (c + b) & ~64'd1;
            K_PANIC: return a;
            default: return pc + 64'd4;
        endcase
    endfunction

    task automatic wait_output(output bit seen);
        int n;
        n = 0;
        @(negedge clk);
        while (pc_o == '0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        seen = (pc_o != '0);
    endtask

    initial begin
        int            base;
        int            kind;
        bit            seen;
        bit            stall_pending;
        if_pkg::addr_t model_pc;

        errors   = 0;
        timeouts = 0;
        rst      = 1'b1;
        pc_delay = 1'b0;
        clear_redirect();
        for (int i = 0; i < 256; i++) begin
            tdata[i] = '0;
        end
        $readmemh("sim/if_testdata.hex", tdata);
        for (int i = 0; i < IMAGE_WORDS; i++) begin
            u_mem.write_word(i, tdata[i][31:0]);
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        check_pc(pc_o, '0, "reset");
        check_inst(inst_o, '0, "reset");
        rst = 1'b0;

        model_pc      = if_pkg::RESET_PC;
        stall_pending = 1'b0;
        base          = STEP_BASE;
        while (base < 256 - STEP_WORDS && tdata[base] != '0 && timeouts == 0) begin
            wait_output(seen);
            if (!seen) begin
                timeouts++;
                $display("Timeout at %0d ns: no instruction came out within %0d cycles",
                         $time, TIMEOUT);
            end else begin
                pc_delay = 1'b0;
                kind = int'(tdata[base+2]);
                check_pc(pc_o, tdata[base], "data file");
                check_pc(pc_o, model_pc, "model");
                check_inst(inst_o, tdata[base+1][31:0], "data file");
                check_size(r_size, EXP_SIZE, "read");
                // a finished stall fetches the same pc once more
                if (!stall_pending) begin
                    model_pc = next_pc(kind, model_pc, tdata[base+3], tdata[base+4],
                                       tdata[base+5]);
                end
                stall_pending = (kind == K_STALL);
                apply_step(kind, tdata[base+3], tdata[base+4], tdata[base+5]);
                base += STEP_WORDS;
            end
        end

        $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/if_stage_chk.sv
`timescale 1ns/1ps
`default_nettype none

module if_stage_chk (
    input logic          clk,
    input logic          rst_i,
    input logic          r_valid_i,
    input logic          r_ready_i,
    input if_pkg::addr_t r_addr_i,
    input logic          data_ready_i
);

    // address phase holds until the memory takes it
    a_addr_hold: assert property (@(posedge clk) disable iff (rst_i)
        r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_addr_i))
        else $error("read address dropped or changed before r_ready");

    // data phase opens only after an accepted address
    a_one_phase: assert property (@(posedge clk) disable iff (rst_i)
        $rose(data_ready_i) |-> $past(r_valid_i && r_ready_i))
        else $error("data phase opened without an address handshake");

    // port stays quiet from the second reset edge on
    a_reset_quiet: assert property (@(posedge clk)
        rst_i && $past(rst_i) |-> !r_valid_i && !data_ready_i)
        else $error("read port active during reset");

endmodule

bind fetch_fsm if_stage_chk u_if_stage_chk (
    .clk          (clk),
    .rst_i        (rst_i),
    .r_valid_i    (r_valid_o),
    .r_ready_i    (r_ready_i),
    .r_addr_i     (r_addr_o),
    .data_ready_i (data_ready_o)
);

`default_nettype wire

// File: sim/rd_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module rd_mem_model (
    input  logic           clk,
    input  logic           rst_i,
    input  logic           r_valid_i,
    output logic           r_ready_o,
    input  if_pkg::addr_t  r_addr_i,
    input  logic           data_ready_i,
    output logic           data_valid_o,
    output if_pkg::rdata_t data_read_o
);

    localparam int            WORDS = 32;
    localparam if_pkg::addr_t BASE  = if_pkg::RESET_PC;

    if_pkg::inst_t mem [0:WORDS-1];
    integer        seed;
    logic [1:0]    addr_dly;
    logic [1:0]    addr_cnt;
    logic [1:0]    data_dly;
    logic [1:0]    data_cnt;
    if_pkg::addr_t rd_addr;
    if_pkg::inst_t rd_word;

    initial begin
        seed = 32'h88be_4e0f;
    end

    task automatic write_word(input int idx, input if_pkg::inst_t value);
        mem[idx] = value;
    endtask

    // ready and valid come once the phase has waited its drawn delay
    assign r_ready_o    = r_valid_i && (addr_cnt == addr_dly);
    assign data_valid_o = data_ready_i && (data_cnt == data_dly);

    // outside the image every address reads its own pattern
    assign rd_word = (rd_addr[63:7] == BASE[63:7]) ? mem[rd_addr[6:2]]
                   : (rd_addr[63:32] ^ rd_addr[31:0] ^ 32'h5a5a_5a5a);

    // upper half is junk the fetch stage must drop
    assign data_read_o = {~rd_word, rd_word};

    always @(posedge clk) begin
        if (rst_i) begin
            addr_cnt <= '0;
            addr_dly <= '0;
            data_cnt <= '0;
            data_dly <= '0;
            rd_addr  <= '0;
        end else begin
            if (r_valid_i && r_ready_o) begin
                addr_cnt <= '0;
                addr_dly <= 2'($random(seed));
                rd_addr  <= r_addr_i;
            end else if (r_valid_i) begin
                addr_cnt <= addr_cnt + 2'd1;
            end
            if (data_ready_i && data_valid_o) begin
                data_cnt <= '0;
                data_dly <= 2'($random(seed));
            end else if (data_ready_i) begin
                data_cnt <= data_cnt + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/if_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module if_stage_top (
    input  logic           clk,
    input  logic           rst_i,
    // stall from later stages
    input  logic           pc_delay_i,
    // redirect requests
    input  logic           jal_i,
    input  logic           jalr_i,
    input  logic           branch_i,
    input  logic           panic_i,
    input  if_pkg::xlen_t  alu_res_i,
    input  if_pkg::addr_t  mtvec_i,
    input  if_pkg::addr_t  me_pc_i,
    input  if_pkg::xlen_t  imm_i,
    input  if_pkg::xlen_t  r1_data_i,
    // fetched instruction, zero on a bubble
    output if_pkg::inst_t  inst_o,
    output if_pkg::addr_t  pc_o,
    // read port, address phase
    output logic           r_valid_o,
    input  logic           r_ready_i,
    output if_pkg::addr_t  r_addr_o,
    output if_pkg::rsize_t r_size_o,
    // read port, data phase
    input  logic           data_valid_i,
    input  if_pkg::rdata_t data_read_i,
    output logic           data_ready_o
);

    logic          redirect_valid;
    if_pkg::addr_t redirect_pc;

    fetch_beat_if beat_if ();

    // instruction reads are always the same size
    assign r_size_o = if_pkg::FETCH_SIZE;

    fetch_fsm u_fetch_fsm (
        .clk          (clk),
        .rst_i        (rst_i),
        .r_valid_o    (r_valid_o),
        .r_ready_i    (r_ready_i),
        .r_addr_o     (r_addr_o),
        .data_valid_i (data_valid_i),
        .data_read_i  (data_read_i),
        .data_ready_o (data_ready_o),
        .beat         (beat_if.fsm)
    );

    branch_target_unit u_branch_target_unit (
        .jal_i            (jal_i),
        .branch_i         (branch_i),
        .jalr_i           (jalr_i),
        .panic_i          (panic_i),
        .alu_res_i        (alu_res_i),
        .me_pc_i          (me_pc_i),
        .imm_i            (imm_i),
        .r1_data_i        (r1_data_i),
        .mtvec_i          (mtvec_i),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc)
    );

    pc_counter u_pc_counter (
        .clk              (clk),
        .rst_i            (rst_i),
        .pc_delay_i       (pc_delay_i),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .beat             (beat_if.pc)
    );

    // compares returned address with the pc and drives the outputs
    inst_capture u_inst_capture (
        .clk    (clk),
        .rst_i  (rst_i),
        .beat   (beat_if.capture),
        .inst_o (inst_o),
        .pc_o   (pc_o)
    );

endmodule

`default_nettype wire

// File: src/inst_capture.sv
`timescale 1ns/1ps
`default_nettype none

module inst_capture (
    input  logic          clk,
    input  logic          rst_i,
    fetch_beat_if.capture beat,
    output if_pkg::inst_t inst_o,
    output if_pkg::addr_t pc_o
);

    if_pkg::inst_t inst_q;
    if_pkg::addr_t pc_q;

    // stale beats from before a redirect fail the compare
    assign beat.accept = beat.beat && (beat.beat_addr == beat.cur_pc);

    // outputs hold one cycle per accepted beat, zero means bubble
    always_ff @(posedge clk) begin
        if (rst_i) begin
            inst_q <= '0;
            pc_q   <= '0;
        end else if (beat.accept) begin
            inst_q <= beat.beat_data[31:0];
            pc_q   <= beat.beat_addr;
        end else begin
            inst_q <= '0;
            pc_q   <= '0;
        end
    end

    assign inst_o = inst_q;
    assign pc_o   = pc_q;

endmodule

`default_nettype wire

// File: src/branch_target_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_target_unit (
    input  logic          jal_i,
    input  logic          branch_i,
    input  logic          jalr_i,
    input  logic          panic_i,
    input  if_pkg::xlen_t alu_res_i,
    input  if_pkg::addr_t me_pc_i,
    input  if_pkg::xlen_t imm_i,
    input  if_pkg::xlen_t r1_data_i,
    input  if_pkg::addr_t mtvec_i,
    output logic          redirect_valid_o,
    output if_pkg::addr_t redirect_pc_o
);

    logic          take_rel;
    if_pkg::addr_t rel_target;
    if_pkg::xlen_t jalr_sum;
    if_pkg::addr_t jalr_target;

    // branch is taken when the compare result is zero
    assign take_rel   = jal_i || (branch_i && (alu_res_i == '0));
    assign rel_target = me_pc_i + imm_i;

    // jalr drops bit 0 of the sum
    assign jalr_sum    = r1_data_i + imm_i;
    assign jalr_target = {jalr_sum[63:1], 1'b0};

    always_comb begin
        redirect_valid_o = 1'b1;
        if (take_rel) begin
            redirect_pc_o = rel_target;
        end else if (jalr_i) begin
            redirect_pc_o = jalr_target;
        end else if (panic_i) begin
            redirect_pc_o = mtvec_i;
        end else begin
            redirect_valid_o = 1'b0;
            redirect_pc_o    = '0;
        end
    end

endmodule

`default_nettype wire

// File: src/pc_counter.sv
`timescale 1ns/1ps
`default_nettype none

module pc_counter (
    input  logic          clk,
    input  logic          rst_i,
    // stall, keeps the pc on the current instruction
    input  logic          pc_delay_i,
    input  logic          redirect_valid_i,
    input  if_pkg::addr_t redirect_pc_i,
    fetch_beat_if.pc      beat
);

    if_pkg::addr_t pc_q;
    if_pkg::addr_t pc_d;
    if_pkg::addr_t pc_next_seq;

    logic step;

    assign pc_next_seq = pc_q + if_pkg::INST_BYTES;

    // only a beat for the current pc moves us on
    assign step = beat.accept && !pc_delay_i;

    // redirect wins over the sequential step
    always_comb begin
        if (redirect_valid_i) begin
            pc_d = redirect_pc_i;
        end else if (step) begin
            pc_d = pc_next_seq;
        end else begin
            pc_d = pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= if_pkg::RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign beat.cur_pc = pc_q;

endmodule

`default_nettype wire

// File: src/fetch_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_fsm (
    input  logic            clk,
    input  logic            rst_i,
    // address phase
    output logic            r_valid_o,
    input  logic            r_ready_i,
    output if_pkg::addr_t   r_addr_o,
    // data phase
    input  logic            data_valid_i,
    input  if_pkg::rdata_t  data_read_i,
    output logic            data_ready_o,
    fetch_beat_if.fsm       beat
);

    if_pkg::fetch_state_e state_q;
    if_pkg::fetch_state_e state_d;

    // address of the read in flight
    if_pkg::addr_t r_addr_q;

    logic addr_hs;
    logic data_hs;

    // handshake outputs decode straight from the state
    assign r_valid_o    = (state_q == if_pkg::ADDR);
    assign data_ready_o = (state_q == if_pkg::DATA);
    assign r_addr_o     = r_addr_q;

    assign addr_hs = r_valid_o && r_ready_i;
    assign data_hs = data_ready_o && data_valid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            if_pkg::IDLE: begin
                state_d = if_pkg::ADDR;
            end
            if_pkg::ADDR: begin
                // wait for the memory to take the address
                if (addr_hs) begin
                    state_d = if_pkg::DATA;
                end
            end
            if_pkg::DATA: begin
                if (data_hs) begin
                    state_d = if_pkg::IDLE;
                end
            end
            default: begin
                state_d = if_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= if_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // latch the pc when a new read starts
    always_ff @(posedge clk) begin
        if (state_q == if_pkg::IDLE) begin
            r_addr_q <= beat.cur_pc;
        end
    end

    // returned beat goes out with the address it was read from
    assign beat.beat      = data_hs;
    assign beat.beat_addr = r_addr_q;
    assign beat.beat_data = data_read_i;

endmodule

`default_nettype wire

// File: src/fetch_beat_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fetch_beat_if;

    // one-cycle data handshake from the read port
    logic           beat;
    // address the returned data belongs to
    if_pkg::addr_t  beat_addr;
    if_pkg::rdata_t beat_data;

    // pc currently held by the counter
    if_pkg::addr_t  cur_pc;

    // beat matches the current pc
    logic           accept;

    modport fsm (
        output beat,
        output beat_addr,
        output beat_data,
        input  cur_pc
    );

    modport pc (
        output cur_pc,
        input  accept
    );

    modport capture (
        input  beat,
        input  beat_addr,
        input  beat_data,
        input  cur_pc,
        output accept
    );

endinterface

`default_nettype wire

// File: src/if_pkg.sv
`default_nettype none

package if_pkg;

    // address and pc width, also used for the read address bus
    typedef logic [63:0] addr_t;

    // register file, immediate and alu result values
    typedef logic [63:0] xlen_t;

    // one 32-bit instruction word
    typedef logic [31:0] inst_t;

    // read data bus, instruction sits in the low half
    typedef logic [63:0] rdata_t;

    // read size code on the bus
    typedef logic [7:0] rsize_t;

    // fetch sequencing
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        ADDR = 2'd1,
        DATA = 2'd2
    } fetch_state_e;

    // first pc after reset
    localparam addr_t RESET_PC = 64'h0000_0000_8000_0000;

    // size code the memory side expects for an instruction read
    localparam rsize_t FETCH_SIZE = 8'h0F;

    // sequential pc step
    localparam addr_t INST_BYTES = 64'd4;

endpackage

`default_nettype wire
